// ==== compile.f ====
logic/cap_sense_pkg.sv
logic/reading_bus_if.sv
logic/capacitive_sensor.sv
logic/capacitive_sensor_array.sv
logic/touch_detector.sv
logic/reading_arbiter.sv
logic/reading_memory.sv
logic/cap_sense_top.sv
verification/sensor_model.sv
verification/cap_sense_tb.sv

// ==== verification/cap_sense_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cap_sense_tb;
	import cap_sense_pkg::*;

	localparam int PIN_RISE_LIMIT = SCAN_PERIOD_CYCLES + 200;
	localparam int PIN_FALL_LIMIT = 200;
	localparam int WRITEBACK_LIMIT = int'(DISCHARGE_WINDOW_CYCLES) + 100;
	localparam int HANDSHAKE_LIMIT = 100;

	logic                         clock;
	logic                         rst_n;
	sensor_vec_t                  sensors_in;
	logic                         sensors_out;
	reading_t                     touch_threshold;
	logic                         host_rd;
	slot_addr_t                   host_addr;
	reading_t                     host_data;
	logic                         host_valid;
	sensor_vec_t                  touched;
	logic [NUM_SENSORS-1:0][15:0] charge_delay;
	logic [NUM_SENSORS-1:0][15:0] fall_delay;
	reading_t                     expected_reading [NUM_SLOTS];
	sensor_vec_t                  expected_touched;
	int unsigned                  rng_state;
	int                           checks;
	int                           value_errors;
	int                           timeouts;
	int                           reads_issued;
	int                           valid_seen;
	int                           charged_cycles;
	logic                         pin_was_high;

	cap_sense_top dut0 (
		.clock           (clock),
		.rst_n           (rst_n),
		.sensors_in      (sensors_in),
		.sensors_out     (sensors_out),
		.touch_threshold (touch_threshold),
		.host_rd         (host_rd),
		.host_addr       (host_addr),
		.host_data       (host_data),
		.host_valid      (host_valid),
		.touched         (touched)
	);

	sensor_model pads0 (
		.clock        (clock),
		.rst_n        (rst_n),
		.charge_pin   (sensors_out),
		.charge_delay (charge_delay),
		.fall_delay   (fall_delay),
		.pads         (sensors_in)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic int unsigned next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return (rng_state >> 16) & 32'h7fff;
	endfunction

	// a pad still high when the window closes reads the full window.
	function automatic int window_reading(input int delay);
		if (delay > int'(DISCHARGE_WINDOW_CYCLES)) begin
			return int'(DISCHARGE_WINDOW_CYCLES);
		end
		return delay;
	endfunction

	function automatic sensor_vec_t flags_for(input logic [NUM_SENSORS-1:0][15:0] fall,
			input int threshold);
		sensor_vec_t flags;
		for (int i = 0; i < NUM_SENSORS; i++) begin
			flags[i] = window_reading(int'(fall[i])) > threshold;
		end
		return flags;
	endfunction

	task automatic compare_value(input string name, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			value_errors++;
			$display("ERROR %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic compare_near(input string name, input int expected, input int actual);
		checks++;
		assert (actual >= expected - 1 && actual <= expected + 1) else begin
			value_errors++;
			$display("ERROR %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
	endtask

	// one host strobe, then wait for the matching host_valid.
	task automatic host_read_check(input string name, input slot_addr_t addr,
			input int expected, input bit slack);
		int cycles;
		@(posedge clock);
		host_rd <= 1'b1;
		host_addr <= addr;
		@(posedge clock);
		host_rd <= 1'b0;
		reads_issued++;
		cycles = 0;
		@(negedge clock);
		while (host_valid !== 1'b1 && cycles < HANDSHAKE_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (host_valid !== 1'b1) begin
			report_timeout($sformatf("host_valid on %s", name));
		end else if (slack) begin
			compare_near(name, expected, int'(host_data));
		end else begin
			compare_value(name, expected, int'(host_data));
		end
	endtask

	task automatic prepare_scan();
		sensor_vec_t                  previous;
		int                           never_pad;
		int                           threshold;
		int                           delay;
		int                           fix_pad;
		logic [NUM_SENSORS-1:0][15:0] charge;
		logic [NUM_SENSORS-1:0][15:0] fall;
		previous = expected_touched;
		threshold = 120 + int'(next_random() % 160);
		never_pad = int'(next_random() % NUM_SENSORS);
		for (int i = 0; i < NUM_SENSORS; i++) begin
			charge[i] = 16'(1 + next_random() % 8);
			delay = 10 + int'(next_random() % 381);
			// stay clear of the threshold, so a one cycle reading error cannot flip a flag.
			if (delay >= threshold - 1 && delay <= threshold + 1) begin
				delay = threshold + 10;
			end
			fall[i] = (i == never_pad) ? 16'hffff : 16'(delay);
		end
		// the new flag pattern must differ from the last one for the update to be seen.
		fix_pad = (never_pad + 1) % NUM_SENSORS;
		if (flags_for(fall, threshold) == previous) begin
			if (window_reading(int'(fall[fix_pad])) > threshold) begin
				fall[fix_pad] = 16'(threshold / 2);
			end else begin
				fall[fix_pad] = 16'(threshold + 50);
			end
		end
		for (int i = 0; i < NUM_SENSORS; i++) begin
			expected_reading[i] = reading_t'(window_reading(int'(fall[i])));
		end
		expected_touched = flags_for(fall, threshold);
		@(posedge clock);
		charge_delay <= charge;
		fall_delay <= fall;
		touch_threshold <= reading_t'(threshold);
	endtask

	task automatic run_scan(input int scan);
		string      tag;
		slot_addr_t addr;
		int         cycles;
		tag = $sformatf("scan%0d", scan);
		cycles = 0;
		while (sensors_out !== 1'b1 && cycles < PIN_RISE_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (sensors_out !== 1'b1) begin
			report_timeout($sformatf("the charge pin to rise in %s", tag));
		end
		cycles = 0;
		while (sensors_out !== 1'b0 && cycles < PIN_FALL_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (sensors_out !== 1'b0) begin
			report_timeout($sformatf("the charge pin to fall in %s", tag));
		end
		// a host read queued behind the write-back lands after all nine slots are written.
		cycles = 0;
		while (dut0.scan_bus.req !== 1'b1 && cycles < WRITEBACK_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (dut0.scan_bus.req !== 1'b1) begin
			report_timeout($sformatf("the write-back to start in %s", tag));
		end
		addr = slot_addr_t'(next_random() % NUM_SENSORS);
		host_read_check($sformatf("%s_writeback_read", tag), addr, expected_reading[addr], 1'b1);
		cycles = 0;
		while (dut0.detect_bus.req !== 1'b1 && cycles < HANDSHAKE_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		if (dut0.detect_bus.req !== 1'b1) begin
			report_timeout($sformatf("the detector pass to start in %s", tag));
		end
		addr = slot_addr_t'(next_random() % NUM_SENSORS);
		host_read_check($sformatf("%s_detect_read", tag), addr, expected_reading[addr], 1'b1);
		cycles = 0;
		while (touched !== expected_touched && cycles < HANDSHAKE_LIMIT) begin
			@(negedge clock);
			cycles++;
		end
		compare_value($sformatf("%s_touched", tag), int'(expected_touched), int'(touched));
		for (int a = 0; a < NUM_SLOTS; a++) begin
			host_read_check($sformatf("%s_slot%0d", tag, a), slot_addr_t'(a),
				int'(expected_reading[a]), a < NUM_SENSORS);
		end
	endtask

	// the confidence count passes its limit after limit plus one cycles with all pads high.
	// the pin drops one cycle after that, so it is seen high for one more such cycle.
	always @(negedge clock) begin
		if (rst_n !== 1'b1) begin
			charged_cycles = 0;
			pin_was_high = 1'b0;
		end else begin
			if (sensors_out === 1'b1 && (&sensors_in) === 1'b1) begin
				charged_cycles++;
			end
			if (pin_was_high && sensors_out === 1'b0) begin
				compare_value("charge_pin_release", int'(CHARGE_CONFIDENCE_CYCLES) + 2,
					charged_cycles);
				charged_cycles = 0;
			end
			pin_was_high = (sensors_out === 1'b1);
		end
	end

	always @(negedge clock) begin
		if (rst_n === 1'b1 && host_valid === 1'b1) begin
			valid_seen++;
		end
	end

	initial begin
		rst_n = 1'b0;
		host_rd = 1'b0;
		host_addr = '0;
		touch_threshold = '0;
		charge_delay = '0;
		fall_delay = '0;
		expected_touched = '0;
		rng_state = 75;
		checks = 0;
		value_errors = 0;
		timeouts = 0;
		reads_issued = 0;
		valid_seen = 0;
		for (int a = 0; a < NUM_SLOTS; a++) begin
			expected_reading[a] = '0;
		end
		repeat (16) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		compare_value("reset_sensors_out", 0, int'(sensors_out));
		compare_value("reset_host_valid", 0, int'(host_valid));
		compare_value("reset_touched", 0, int'(touched));
		for (int a = 0; a < NUM_SLOTS; a++) begin
			host_read_check($sformatf("reset_slot%0d", a), slot_addr_t'(a), 0, 1'b0);
		end
		prepare_scan();
		run_scan(1);
		prepare_scan();
		run_scan(2);
		// the last host_valid pulse is counted on the same falling edge that ended its wait.
		@(posedge clock);
		compare_value("host_valid_count", reads_issued, valid_seen);
		$display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/sensor_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// nine pads that share one charge pin.
// each pad rises a set number of cycles after the pin goes high.
// once the pin is released, each pad falls after its own delay.
module sensor_model (
	input  logic                                        clock,
	input  logic                                        rst_n,
	input  logic                                        charge_pin,
	input  logic [cap_sense_pkg::NUM_SENSORS-1:0][15:0] charge_delay,
	input  logic [cap_sense_pkg::NUM_SENSORS-1:0][15:0] fall_delay,
	output cap_sense_pkg::sensor_vec_t                  pads
);
	import cap_sense_pkg::*;

	int high_cycles;
	int low_cycles;

	initial begin
		pads = '0;
		high_cycles = 0;
		low_cycles = 0;
	end

	always @(posedge clock) begin
		if (!rst_n) begin
			pads <= '0;
			high_cycles <= 0;
			low_cycles <= 0;
		end else if (charge_pin) begin
			low_cycles <= 0;
			high_cycles <= high_cycles + 1;
			for (int i = 0; i < NUM_SENSORS; i++) begin
				if (high_cycles + 1 >= int'(charge_delay[i])) begin
					pads[i] <= 1'b1;
				end
			end
		end else begin
			high_cycles <= 0;
			// saturates far above any delay, so a long idle gap cannot wrap.
			if (low_cycles < 100000) begin
				low_cycles <= low_cycles + 1;
			end
			for (int i = 0; i < NUM_SENSORS; i++) begin
				if (low_cycles + 1 >= int'(fall_delay[i])) begin
					pads[i] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/cap_sense_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cap_sense_top (
	input  logic                       clock,
	input  logic                       rst_n,
	input  cap_sense_pkg::sensor_vec_t sensors_in,
	output logic                       sensors_out,
	input  cap_sense_pkg::reading_t    touch_threshold,
	input  logic                       host_rd,
	input  cap_sense_pkg::slot_addr_t  host_addr,
	output cap_sense_pkg::reading_t    host_data,
	output logic                       host_valid,
	output cap_sense_pkg::sensor_vec_t touched
);
	import cap_sense_pkg::*;

	logic       scan_done;
	logic       host_pending;
	slot_addr_t host_addr_q;

	reading_bus_if scan_bus ();
	reading_bus_if detect_bus ();
	reading_bus_if host_bus ();
	reading_bus_if mem_bus ();

	// host request holder. a strobe is dropped while an earlier one still waits for its grant.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			host_pending <= 1'b0;
		end else if (host_bus.gnt) begin
			host_pending <= 1'b0;
		end else if (host_rd) begin
			host_pending <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (host_rd && !host_pending) begin
			host_addr_q <= host_addr;
		end
	end

	assign host_bus.req = host_pending;
	assign host_bus.we = 1'b0;
	assign host_bus.addr = host_addr_q;
	assign host_bus.wdata = '0;
	assign host_data = host_bus.rdata;

	capacitive_sensor_array u_array (
		.clock       (clock),
		.rst_n       (rst_n),
		.sensors_in  (sensors_in),
		.sensors_out (sensors_out),
		.scan_done   (scan_done),
		.mem         (scan_bus)
	);

	touch_detector u_detect (
		.clock           (clock),
		.rst_n           (rst_n),
		.scan_done       (scan_done),
		.touch_threshold (touch_threshold),
		.touched         (touched),
		.mem             (detect_bus)
	);

	reading_arbiter u_arb (
		.clock           (clock),
		.rst_n           (rst_n),
		.scan_port       (scan_bus),
		.detect_port     (detect_bus),
		.host_port       (host_bus),
		.mem             (mem_bus),
		.host_read_valid (host_valid)
	);

	reading_memory u_mem (
		.clock (clock),
		.rst_n (rst_n),
		.port  (mem_bus)
	);

endmodule

`default_nettype wire

// ==== logic/reading_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module reading_memory (
	input  logic          clock,
	input  logic          rst_n,
	reading_bus_if.memory port
);
	import cap_sense_pkg::*;

	reading_t slots [NUM_SLOTS];

	// single port, accepts every enabled cycle.
	assign port.gnt = port.req;

	// slots 9 to 15 are never written, so they keep the zero from reset.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				slots[i] <= '0;
			end
			port.rdata <= '0;
		end else if (port.req) begin
			if (port.we) begin
				slots[port.addr] <= port.wdata;
			end else begin
				port.rdata <= slots[port.addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/reading_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module reading_arbiter (
	input  logic           clock,
	input  logic           rst_n,
	reading_bus_if.arbiter scan_port,
	reading_bus_if.arbiter detect_port,
	reading_bus_if.arbiter host_port,
	reading_bus_if.client  mem,
	output logic           host_read_valid
);

	logic sel_scan;
	logic sel_detect;
	logic sel_host;

	// fixed priority: scan write-back first, then the detector, then the host.
	assign sel_scan = scan_port.req;
	assign sel_detect = detect_port.req && !scan_port.req;
	assign sel_host = host_port.req && !scan_port.req && !detect_port.req;

	assign mem.req = scan_port.req || detect_port.req || host_port.req;

	always_comb begin
		if (sel_scan) begin
			mem.we = scan_port.we;
			mem.addr = scan_port.addr;
			mem.wdata = scan_port.wdata;
		end else if (sel_detect) begin
			mem.we = detect_port.we;
			mem.addr = detect_port.addr;
			mem.wdata = detect_port.wdata;
		end else begin
			mem.we = host_port.we;
			mem.addr = host_port.addr;
			mem.wdata = host_port.wdata;
		end
	end

	assign scan_port.gnt = sel_scan && mem.gnt;
	assign detect_port.gnt = sel_detect && mem.gnt;
	assign host_port.gnt = sel_host && mem.gnt;

	// read data is broadcast, each client knows when it is its own.
	assign scan_port.rdata = mem.rdata;
	assign detect_port.rdata = mem.rdata;
	assign host_port.rdata = mem.rdata;

	// marks the host as owner of the read data arriving next cycle.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			host_read_valid <= 1'b0;
		end else begin
			host_read_valid <= host_port.gnt && !host_port.we;
		end
	end

endmodule

`default_nettype wire

// ==== logic/touch_detector.sv ====
`timescale 1ns/1ps
`default_nettype none

module touch_detector (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic                       scan_done,
	input  cap_sense_pkg::reading_t    touch_threshold,
	output cap_sense_pkg::sensor_vec_t touched,
	reading_bus_if.client              mem
);
	import cap_sense_pkg::*;

	logic        active;
	slot_addr_t  rd_index;
	logic        ret_valid;
	slot_addr_t  ret_index;
	logic        pass_end;
	sensor_vec_t shadow;

	// request side. reads are issued back to back, one slot per grant.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			active <= 1'b0;
			rd_index <= '0;
			ret_valid <= 1'b0;
			pass_end <= 1'b0;
			touched <= '0;
		end else begin
			ret_valid <= mem.req && mem.gnt;
			pass_end <= ret_valid && (ret_index == slot_addr_t'(NUM_SENSORS - 1));
			if (scan_done) begin
				active <= 1'b1;
				rd_index <= '0;
			end else if (mem.req && mem.gnt) begin
				if (rd_index == slot_addr_t'(NUM_SENSORS - 1)) begin
					active <= 1'b0;
				end
				rd_index <= rd_index + 4'd1;
			end
			// all flags change together once the last comparison has landed.
			if (pass_end) begin
				touched <= shadow;
			end
		end
	end

	// return side. rdata belongs to the slot granted one cycle earlier.
	always_ff @(posedge clock) begin
		ret_index <= rd_index;
		if (ret_valid) begin
			shadow[ret_index] <= (mem.rdata > touch_threshold);
		end
	end

	assign mem.req = active;
	assign mem.we = 1'b0;
	assign mem.addr = rd_index;
	assign mem.wdata = '0;

endmodule

`default_nettype wire

// ==== logic/capacitive_sensor_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module capacitive_sensor_array (
	input  logic                       clock,
	input  logic                       rst_n,
	input  cap_sense_pkg::sensor_vec_t sensors_in,
	output logic                       sensors_out,
	output logic                       scan_done,
	reading_bus_if.client              mem
);
	import cap_sense_pkg::*;

	scan_state_t   state;
	period_count_t period_count;
	count_t        charge_count;
	count_t        window_count;
	slot_addr_t    wb_index;
	logic          wb_settle;
	logic          period_wrap;
	logic          measure;
	reading_t      readings [NUM_SENSORS];

	assign period_wrap = (period_count == period_count_t'(SCAN_PERIOD_CYCLES - 1));

	// free running scan period counter.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			period_count <= '0;
		end else if (period_wrap) begin
			period_count <= '0;
		end else begin
			period_count <= period_count + 10'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= IDLE;
			sensors_out <= 1'b0;
			scan_done <= 1'b0;
			charge_count <= '0;
			window_count <= '0;
			wb_index <= '0;
			wb_settle <= 1'b0;
		end else begin
			scan_done <= 1'b0;
			case (state)
				IDLE: begin
					charge_count <= '0;
					if (period_wrap) begin
						state <= CHARGE;
					end
				end
				CHARGE: begin
					if (charge_count > CHARGE_CONFIDENCE_CYCLES) begin
						sensors_out <= 1'b0;
						window_count <= '0;
						state <= DISCHARGE;
					end else begin
						sensors_out <= 1'b1;
						// the confidence count is cumulative and never restarts inside a scan.
						if (sensors_out && (&sensors_in)) begin
							charge_count <= charge_count + 16'd1;
						end
					end
				end
				DISCHARGE: begin
					window_count <= window_count + 16'd1;
					if (window_count == DISCHARGE_WINDOW_CYCLES - 16'd1) begin
						wb_index <= '0;
						wb_settle <= 1'b1;
						state <= WRITEBACK;
					end
				end
				WRITEBACK: begin
					// pads that never fell update their reading one cycle after measure drops.
					wb_settle <= 1'b0;
					if (mem.req && mem.gnt) begin
						if (wb_index == slot_addr_t'(NUM_SENSORS - 1)) begin
							scan_done <= 1'b1;
							state <= IDLE;
						end else begin
							wb_index <= wb_index + 4'd1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign measure = (state == DISCHARGE);

	for (genvar i = 0; i < NUM_SENSORS; i++) begin : g_pad
		capacitive_sensor u_pad (
			.clock     (clock),
			.rst_n     (rst_n),
			.measure   (measure),
			.sensor_in (sensors_in[i]),
			.reading   (readings[i])
		);
	end

	// write-back of reading i to address i, one slot per grant.
	assign mem.req = (state == WRITEBACK) && !wb_settle;
	assign mem.we = 1'b1;
	assign mem.addr = wb_index;
	assign mem.wdata = readings[wb_index];

endmodule

`default_nettype wire

// ==== logic/capacitive_sensor.sv ====
`timescale 1ns/1ps
`default_nettype none

module capacitive_sensor (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    measure,
	input  logic                    sensor_in,
	output cap_sense_pkg::reading_t reading
);
	import cap_sense_pkg::*;

	reading_t count;
	logic     captured;
	logic     measure_q;

	// count cycles since discharge began.
	// the first low sample of the pad input freezes the reading.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			count <= '0;
			captured <= 1'b0;
			measure_q <= 1'b0;
			reading <= '0;
		end else begin
			measure_q <= measure;
			if (measure) begin
				count <= count + 16'd1;
				if (!captured && !sensor_in) begin
					reading <= count;
					captured <= 1'b1;
				end
			end else begin
				count <= '0;
				captured <= 1'b0;
				// the pad never fell inside the window, so it reads the full window.
				if (measure_q && !captured) begin
					reading <= DISCHARGE_WINDOW_CYCLES;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/reading_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one access port onto the reading memory.
// a client holds req and its fields until gnt is high, and read data follows a cycle later.
interface reading_bus_if;
	import cap_sense_pkg::*;

	logic       req;
	logic       we;
	slot_addr_t addr;
	reading_t   wdata;
	logic       gnt;
	reading_t   rdata;

	modport client (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

	// req acts as the memory enable on this side.
	modport memory (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

`default_nettype wire

// ==== logic/cap_sense_pkg.sv ====
`default_nettype none

package cap_sense_pkg;

	// pad count and reading memory geometry.
	localparam int NUM_SENSORS = 9;
	localparam int NUM_SLOTS = 16;

	// all timing below is in clock cycles.
	// the charge pin stays high until every pad has read high for more than this many cycles.
	localparam logic [15:0] CHARGE_CONFIDENCE_CYCLES = 16'd20;

	// a pad that is still high at the end of the window reads exactly this value.
	localparam logic [15:0] DISCHARGE_WINDOW_CYCLES = 16'd400;

	// distance between two scan starts.
	localparam int SCAN_PERIOD_CYCLES = 1000;

	// one discharge reading.
	typedef logic [15:0] reading_t;

	// one bit per pad, for pad inputs and touched flags.
	typedef logic [NUM_SENSORS-1:0] sensor_vec_t;

	// reading memory address, pad i lives at address i.
	typedef logic [3:0] slot_addr_t;

	// sequencer cycle counters for the charge and discharge phases.
	typedef logic [15:0] count_t;

	// scan period counter, wide enough for SCAN_PERIOD_CYCLES.
	typedef logic [9:0] period_count_t;

	typedef enum logic [1:0] {
		IDLE,
		CHARGE,
		DISCHARGE,
		WRITEBACK
	} scan_state_t;

endpackage

`default_nettype wire
